//--- build.f
+incdir+.
debugPkg.sv
serialFramer.sv
msgQueue.sv
replySender.sv
serialShifter.sv
cmdHandler.sv
debugLinkTop.sv
tbDebugLink.sv

//--- cmdHandler.sv
`timescale 1ns/100ps
`include "debug_defines.svh"

module cmdHandler import debugPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  msgWord inHead,
    input  logic   inEmpty,
    output logic   inPop,
    input  logic   senderBusy,
    output logic   replyStart,
    output dbgByte replyType,
    output dbgByte replyLen,
    input  logic   payloadTake,
    output dbgByte replyByte,
    output ledVec  led
);

    handlerState state;
    msgWord      msgReg;
    msgPayload   payload;
    memAddr      curAddr;
    memWord      wordData;
    logic [6:0]  wordCount;
    logic        started;
    logic        hiSel;

    assign payload = msgReg[$bits(msgWord)-1:16];

    // Memory pattern: every word holds its own address
    assign wordData = memWord'(curAddr);

    assign inPop      = (state == handlerIdle) && !inEmpty;
    assign replyStart = (state == handlerBusy) && !started && !senderBusy;
    assign replyType  = `MsgTypeReadMem;
    assign replyLen   = {wordCount, 1'b0};
    // Low byte first, then high byte
    assign replyByte  = hiSel ? wordData[15:8] : wordData[7:0];

    // ======================================================================
    // Command FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= handlerIdle;
            led     <= '0;
            started <= 1'b0;
            hiSel   <= 1'b0;
        end else begin
            case (state)
                handlerIdle: begin
                    if (inPop) begin
                        state <= decode;
                    end
                end
                decode: begin
                    state   <= handlerIdle;
                    started <= 1'b0;
                    hiSel   <= 1'b0;
                    if (msgReg[7:0] == `MsgTypeSetLed) begin
                        led <= payload[`LedWidth-1:0];
                    end else if (msgReg[7:0] == `MsgTypeReadMem) begin
                        state <= handlerBusy;
                    end
                end
                default: begin
                    if (replyStart) begin
                        started <= 1'b1;
                    end
                    if (payloadTake) begin
                        hiSel <= !hiSel;
                    end
                    // Sender drops busy after its last payload byte
                    if (started && !senderBusy) begin
                        state <= handlerIdle;
                    end
                end
            endcase
        end
    end

    // Message capture and ReadMem address walk
    always_ff @(posedge clk) begin
        if (inPop) begin
            msgReg <= inHead;
        end
        if (state == decode) begin
            curAddr   <= {payload[15:8], payload[7:0]};
            wordCount <= (payload[23:16] > `ReadMemMaxWords) ? 7'(`ReadMemMaxWords)
                                                              : payload[22:16];
        end else if (payloadTake && hiSel) begin
            // Wraps at 16 bits
            curAddr <= curAddr + 16'd1;
        end
    end

endmodule

//--- debugLinkTop.sv
`timescale 1ns/100ps
`include "debug_defines.svh"

module debugLinkTop import debugPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  serialCs,
    input  logic  serialStrobe,
    input  logic  serialDi,
    output logic  serialDo,
    output ledVec led
);

    // Inbound path
    logic   inPush;
    msgWord inPushMsg;
    logic   inPop;
    msgWord inHead;
    logic   inEmpty;
    logic   inFull;

    // Handler to sender
    logic   senderBusy;
    logic   replyStart;
    dbgByte replyType;
    dbgByte replyLen;
    logic   payloadTake;
    dbgByte replyByte;

    // Outbound path
    logic   outPush;
    dbgByte outData;
    logic   outPop;
    dbgByte outHead;
    logic   outEmpty;
    logic   outFull;

    serialFramer framer (
        .clk(clk), .rst(rst), .serialCs(serialCs), .serialStrobe(serialStrobe),
        .serialDi(serialDi), .pushEn(inPush), .pushMsg(inPushMsg), .queueFull(inFull)
    );

    msgQueue #(.Width($bits(msgWord)), .Depth(`InQueueDepth)) inQueue (
        .clk(clk), .rst(rst), .push(inPush), .pushData(inPushMsg), .pop(inPop),
        .headData(inHead), .empty(inEmpty), .full(inFull)
    );

    cmdHandler handler (
        .clk(clk), .rst(rst), .inHead(inHead), .inEmpty(inEmpty), .inPop(inPop),
        .senderBusy(senderBusy), .replyStart(replyStart), .replyType(replyType),
        .replyLen(replyLen), .payloadTake(payloadTake), .replyByte(replyByte), .led(led)
    );

    replySender sender (
        .clk(clk), .rst(rst), .replyStart(replyStart), .replyType(replyType),
        .replyLen(replyLen), .busy(senderBusy), .payloadTake(payloadTake),
        .replyByte(replyByte), .outPush(outPush), .outData(outData), .outFull(outFull)
    );

    msgQueue #(.Width($bits(dbgByte)), .Depth(`OutQueueDepth)) outQueue (
        .clk(clk), .rst(rst), .push(outPush), .pushData(outData), .pop(outPop),
        .headData(outHead), .empty(outEmpty), .full(outFull)
    );

    serialShifter shifter (
        .clk(clk), .rst(rst), .serialCs(serialCs), .serialStrobe(serialStrobe),
        .outHead(outHead), .outEmpty(outEmpty), .outPop(outPop), .serialDo(serialDo)
    );

endmodule

//--- debugPkg.sv
`include "debug_defines.svh"

package debugPkg;

    // Serial link byte
    typedef logic [7:0] dbgByte;

    // Payload of one inbound message, byte 0 in the low bits
    typedef logic [`MsgMaxPayloadLen*8-1:0] msgPayload;

    // Inbound queue entry: type, length, then payload from the low bits up
    typedef logic [(`MsgHeaderLen+`MsgMaxPayloadLen)*8-1:0] msgWord;

    // Memory word and its address
    typedef logic [15:0] memAddr;
    typedef logic [15:0] memWord;

    typedef logic [`LedWidth-1:0] ledVec;

    // FSM states
    typedef enum logic [1:0] {waitType, waitLen, takePayload} framerState;
    typedef enum logic [1:0] {senderIdle, sendType, sendLen, sendPayload} senderState;
    typedef enum logic [1:0] {handlerIdle, decode, handlerBusy} handlerState;

endpackage

//--- debug_defines.svh
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

// Message framing
// Payload bytes kept per message, extra bytes are counted and dropped
`define MsgMaxPayloadLen 5
// Type byte plus length byte
`define MsgHeaderLen 2

// Queue depths in entries
`define InQueueDepth 4
`define OutQueueDepth 4

// Message type codes
`define MsgTypeSetLed 8'h01
`define MsgTypeReadMem 8'h02

// Largest word count a single ReadMem reply carries
`define ReadMemMaxWords 127

`define LedWidth 4

`endif

//--- msgQueue.sv
`timescale 1ns/100ps

module msgQueue #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    input  logic             pop,
    output logic [Width-1:0] headData,
    output logic             empty,
    output logic             full
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    logic [Width-1:0]      mem [Depth];
    logic [PtrWidth-1:0]   rdPtr;
    logic [PtrWidth-1:0]   wrPtr;
    logic [CountWidth-1:0] count;

    // Head is shown combinationally
    assign headData = mem[rdPtr];
    assign empty    = (count == '0);
    assign full     = (count == CountWidth'(Depth));

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Producers and consumers must honour the flags
    assert property (@(posedge clk) disable iff (rst) push |-> !full);
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- replySender.sv
`timescale 1ns/100ps

module replySender import debugPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   replyStart,
    input  dbgByte replyType,
    input  dbgByte replyLen,
    output logic   busy,
    output logic   payloadTake,
    input  dbgByte replyByte,
    output logic   outPush,
    output dbgByte outData,
    input  logic   outFull
);

    senderState state;
    dbgByte     typeReg;
    dbgByte     lenReg;
    dbgByte     payloadCount;

    assign busy = (state != senderIdle);

    // One byte per cycle whenever the outbound queue has room
    always_comb begin
        outPush     = 1'b0;
        payloadTake = 1'b0;
        outData     = typeReg;
        case (state)
            sendType: begin
                outPush = !outFull;
            end
            sendLen: begin
                outPush = !outFull;
                outData = lenReg;
            end
            sendPayload: begin
                outPush     = !outFull;
                payloadTake = !outFull;
                outData     = replyByte;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= senderIdle;
            payloadCount <= 8'd0;
        end else begin
            case (state)
                senderIdle: begin
                    if (replyStart) begin
                        state <= sendType;
                    end
                end
                sendType: begin
                    if (outPush) begin
                        state <= sendLen;
                    end
                end
                sendLen: begin
                    payloadCount <= 8'd0;
                    if (outPush) begin
                        state <= (lenReg == 8'd0) ? senderIdle : sendPayload;
                    end
                end
                default: begin
                    if (outPush) begin
                        payloadCount <= payloadCount + 8'd1;
                        if ((payloadCount + 8'd1) == lenReg) begin
                            state <= senderIdle;
                        end
                    end
                end
            endcase
        end
    end

    // Header latched at the start of a reply
    always_ff @(posedge clk) begin
        if (replyStart && !busy) begin
            typeReg <= replyType;
            lenReg  <= replyLen;
        end
    end

    // The handler waits for the previous reply before starting another
    assert property (@(posedge clk) disable iff (rst) replyStart |-> !busy);

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbDebugLink -f build.f -o simDebugLink

./obj_dir/simDebugLink > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log
exit 0

//--- serialFramer.sv
`timescale 1ns/100ps
`include "debug_defines.svh"

module serialFramer import debugPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   serialCs,
    input  logic   serialStrobe,
    input  logic   serialDi,
    output logic   pushEn,
    output msgWord pushMsg,
    input  logic   queueFull
);

    framerState state;

    // Sentinel bit walks up from bit 0, a byte is whole when it reaches bit 8
    logic [8:0] shiftReg;
    logic [8:0] shiftNext;
    logic       byteTaken;
    dbgByte     newByte;
    dbgByte     payloadCount;
    msgWord     msgReg;
    logic       msgDone;

    assign shiftNext = (shiftReg << 1) | 9'(serialDi);
    assign newByte   = shiftNext[7:0];
    assign byteTaken = serialCs && serialStrobe && shiftNext[8];

    // Zero length completes on the length byte itself
    assign msgDone = byteTaken &&
                     ((state == waitLen && newByte == 8'd0) ||
                      (state == takePayload && (payloadCount + 8'd1) == msgReg[15:8]));

    assign pushMsg = msgReg;

    // ======================================================================
    // Framing FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst || !serialCs) begin
            state        <= waitType;
            shiftReg     <= 9'h001;
            payloadCount <= 8'd0;
            pushEn       <= 1'b0;
        end else begin
            pushEn <= msgDone && !queueFull;
            if (serialStrobe) begin
                shiftReg <= shiftNext[8] ? 9'h001 : shiftNext;
            end
            if (byteTaken) begin
                case (state)
                    waitType: begin
                        // Zero bytes between messages are idle filler
                        if (newByte != 8'd0) begin
                            state <= waitLen;
                        end
                    end
                    waitLen: begin
                        payloadCount <= 8'd0;
                        state        <= (newByte == 8'd0) ? waitType : takePayload;
                    end
                    default: begin
                        payloadCount <= payloadCount + 8'd1;
                        if (msgDone) begin
                            state <= waitType;
                        end
                    end
                endcase
            end
        end
    end

    // Message register, payload zero-filled when the length arrives
    always_ff @(posedge clk) begin
        if (byteTaken) begin
            case (state)
                waitType: msgReg[7:0] <= newByte;
                waitLen: begin
                    msgReg[15:8]                  <= newByte;
                    msgReg[$bits(msgWord)-1:16]   <= '0;
                end
                default: begin
                    if (payloadCount < `MsgMaxPayloadLen) begin
                        msgReg[8*(int'(payloadCount) + `MsgHeaderLen) +: 8] <= newByte;
                    end
                end
            endcase
        end
    end

    // Full messages are dropped, never pushed into a full inbound queue
    assert property (@(posedge clk) disable iff (rst) pushEn |-> !queueFull);

endmodule

//--- serialShifter.sv
`timescale 1ns/100ps

module serialShifter import debugPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   serialCs,
    input  logic   serialStrobe,
    input  dbgByte outHead,
    input  logic   outEmpty,
    output logic   outPop,
    output logic   serialDo
);

    dbgByte     outReg;
    // Bits still to show after the current one, zero at a byte boundary
    logic [2:0] bitCount;
    logic       atBoundary;

    assign atBoundary = (bitCount == 3'd0);
    assign serialDo   = outReg[7];

    // Pop only on a boundary strobe with a byte waiting
    assign outPop = serialCs && serialStrobe && atBoundary && !outEmpty;

    always_ff @(posedge clk) begin
        if (rst || !serialCs) begin
            outReg   <= 8'd0;
            bitCount <= 3'd0;
        end else if (serialStrobe) begin
            if (atBoundary) begin
                // Zero filler keeps the line idle when nothing is queued
                outReg   <= outEmpty ? 8'd0 : outHead;
                bitCount <= 3'd7;
            end else begin
                outReg   <= outReg << 1;
                bitCount <= bitCount - 3'd1;
            end
        end
    end

endmodule

//--- tbDebugLink.sv
`timescale 1ns/100ps
`include "debug_defines.svh"

module tbDebugLink import debugPkg::*; ();

    localparam int DriveDelay = 10;
    localparam logic [31:0] LfsrSeed = 32'h614e8e2a;
    // Right-shift Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    // Six ReadMem replies of up to 254 bytes dominate the byte count
    localparam int MaxBytesSent  = 2000;
    // Eight strobes per byte, at most five cycles per strobe
    localparam int TimeoutCycles = MaxBytesSent * 8 * 5 + 1000;

    typedef enum logic [1:0] {rxIdle, rxLen, rxPayload} decoderState;

    logic  clk = 1'b0;
    logic  rst;
    logic  serialCs;
    logic  serialStrobe;
    logic  serialDi;
    logic  serialDo;
    ledVec led;

    logic [31:0] lfsrState;
    int          cycleCount = 0;
    int          strobeCount = 0;

    // Serial receive side
    dbgByte      rxShift;
    int          rxBits;
    decoderState decState;
    int          payloadLeft;

    // Expected reply bytes, and the bytes of the next message to send
    dbgByte      expQ[$];
    dbgByte      txBuf[$];
    ledVec       expLed;

    debugLinkTop i_dut (
        .clk(clk), .rst(rst), .serialCs(serialCs), .serialStrobe(serialStrobe),
        .serialDi(serialDi), .serialDo(serialDo), .led(led)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("ERROR at time %0t: test did not finish within %0d cycles",
                     $time, TimeoutCycles);
            endWithFailure();
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic endWithFailure();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkLed(input ledVec actual, input ledVec expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: led = %h, expected %h", $time, actual, expected);
            endWithFailure();
        end
    endtask

    task automatic checkByte(input string name, input dbgByte actual, input dbgByte expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s = %h, expected %h", $time, name, actual, expected);
            endWithFailure();
        end
    endtask

    task automatic checkLen(input dbgByte actual, input dbgByte expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: reply length = %h, expected %h",
                     $time, actual, expected);
            endWithFailure();
        end
    endtask

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ LfsrTaps;
            end
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    // ======================================================================
    // Serial model and reply decoder
    // ======================================================================
    task automatic takeExpected(output dbgByte value);
        if (expQ.size() == 0) begin
            $display("ERROR at time %0t: reply carries more bytes than expected", $time);
            endWithFailure();
        end else begin
            value = expQ.pop_front();
        end
    endtask

    task automatic decodeByte(input dbgByte value);
        dbgByte expected;
        case (decState)
            rxIdle: begin
                if (expQ.size() == 0) begin
                    checkByte("filler byte", value, 8'h00);
                end else if (value != 8'h00) begin
                    takeExpected(expected);
                    checkByte("reply type", value, expected);
                    decState = rxLen;
                end
            end
            rxLen: begin
                takeExpected(expected);
                checkLen(value, expected);
                payloadLeft = int'(value);
                decState    = (value == 8'h00) ? rxIdle : rxPayload;
            end
            default: begin
                takeExpected(expected);
                checkByte("reply payload", value, expected);
                payloadLeft--;
                if (payloadLeft == 0) begin
                    decState = rxIdle;
                end
            end
        endcase
    endtask

    task automatic receiveBit(input logic bitVal);
        rxShift = {rxShift[6:0], bitVal};
        rxBits++;
        if (rxBits == 8) begin
            rxBits = 0;
            decodeByte(rxShift);
        end
    endtask

    // One strobe, then a gap of 2 to 5 cycles to the next one
    task automatic strobeBit(input logic bitVal);
        int gap;
        serialDi     = bitVal;
        serialStrobe = 1'b1;
        @(posedge clk);
        #DriveDelay;
        serialStrobe = 1'b0;
        strobeCount++;
        receiveBit(serialDo);
        gap = 2 + int'(randBits(2));
        repeat (gap - 1) begin
            @(posedge clk);
            #DriveDelay;
        end
    endtask

    // MSB first
    task automatic sendBits(input dbgByte value, input int nBits);
        dbgByte bits;
        bits = value;
        repeat (nBits) begin
            strobeBit(bits[7]);
            bits = bits << 1;
        end
    endtask

    task automatic sendByte(input dbgByte value);
        sendBits(value, 8);
    endtask

    task automatic sendLeadingZeros();
        int n;
        n = int'(randBits(2));
        repeat (n) sendByte(8'h00);
    endtask

    task automatic sendQueuedBytes();
        for (int i = 0; i < txBuf.size(); i++) begin
            sendByte(txBuf[i]);
        end
        txBuf.delete();
    endtask

    task automatic dropChipSelect();
        serialCs = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #DriveDelay;
        end
        serialCs = 1'b1;
        // Byte boundaries restart with the chip select
        rxBits   = 0;
        rxShift  = 8'h00;
        decState = rxIdle;
    endtask

    // Idle bytes keep the strobes going while replies come out
    task automatic waitReplies(input int boundBytes);
        int n;
        n = 0;
        while ((expQ.size() != 0 || decState != rxIdle) && n < boundBytes) begin
            sendByte(8'h00);
            n++;
        end
        if (expQ.size() != 0 || decState != rxIdle) begin
            $display("ERROR at time %0t: reply incomplete after %0d idle bytes", $time, n);
            endWithFailure();
        end
    endtask

    task automatic waitLedUpdate(input ledVec prevLed);
        int n;
        n = 0;
        while (led === prevLed && n < 3) begin
            sendByte(8'h00);
            n++;
        end
    endtask

    // ======================================================================
    // Test steps
    // ======================================================================
    task automatic expectReadMem(input memAddr start, input dbgByte count);
        int     words;
        memAddr addr;
        words = (count > `ReadMemMaxWords) ? `ReadMemMaxWords : int'(count);
        expQ.push_back(`MsgTypeReadMem);
        expQ.push_back(dbgByte'(2 * words));
        for (int i = 0; i < words; i++) begin
            addr = start + memAddr'(i);
            expQ.push_back(addr[7:0]);
            expQ.push_back(addr[15:8]);
        end
    endtask

    task automatic runSetLed(input dbgByte value, input int payloadLen);
        ledVec prevLed;
        prevLed = expLed;
        sendLeadingZeros();
        txBuf.push_back(`MsgTypeSetLed);
        txBuf.push_back(dbgByte'(payloadLen));
        txBuf.push_back(value);
        for (int i = 1; i < payloadLen; i++) begin
            txBuf.push_back(dbgByte'(randBits(8)));
        end
        sendQueuedBytes();
        expLed = value[`LedWidth-1:0];
        waitLedUpdate(prevLed);
        checkLed(led, expLed);
    endtask

    task automatic runReadMem(input memAddr start, input dbgByte count, input int extraBytes);
        sendLeadingZeros();
        txBuf.push_back(`MsgTypeReadMem);
        txBuf.push_back(dbgByte'(3 + extraBytes));
        txBuf.push_back(start[7:0]);
        txBuf.push_back(start[15:8]);
        txBuf.push_back(count);
        repeat (extraBytes) txBuf.push_back(dbgByte'(randBits(8)));
        expectReadMem(start, count);
        sendQueuedBytes();
        waitReplies(expQ.size() + 4);
    endtask

    task automatic runUnknownType();
        dbgByte msgType;
        // Codes 8'h80 and up are never SetLED or ReadMem
        msgType = {1'b1, 7'(randBits(7))};
        sendLeadingZeros();
        txBuf.push_back(msgType);
        txBuf.push_back(8'd2);
        txBuf.push_back(dbgByte'(randBits(8)));
        txBuf.push_back(dbgByte'(randBits(8)));
        sendQueuedBytes();
        repeat (4) sendByte(8'h00);
        checkLed(led, expLed);
    endtask

    task automatic runDroppedMessage();
        dbgByte value;
        value = {4'(randBits(4)), ~expLed};
        sendLeadingZeros();
        sendByte(`MsgTypeSetLed);
        sendByte(8'd1);
        sendBits(value, 7);
        dropChipSelect();
        repeat (4) sendByte(8'h00);
        checkLed(led, expLed);
        runSetLed(dbgByte'(randBits(8)), 1);
    endtask

    initial begin
        memAddr start;
        dbgByte count;

        lfsrState    = LfsrSeed;
        rst          = 1'b1;
        serialCs     = 1'b0;
        serialStrobe = 1'b0;
        serialDi     = 1'b0;
        rxShift      = 8'h00;
        rxBits       = 0;
        decState     = rxIdle;
        payloadLeft  = 0;
        expLed       = '0;

        repeat (4) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        // Idle state after reset
        checkLed(led, '0);
        serialCs = 1'b1;
        repeat (4) sendByte(8'h00);
        checkLed(led, '0);

        for (int i = 0; i < 8; i++) begin
            runSetLed(dbgByte'(randBits(8)), 1 + int'(randBits(1)) + int'(randBits(1)));
        end

        // First two replies are clamped and cross the top of the address space
        for (int i = 0; i < 6; i++) begin
            if (i < 2) begin
                start = 16'hFF80 | memAddr'(randBits(7));
                count = {1'b1, 7'(randBits(7))};
            end else begin
                start = memAddr'(randBits(16));
                count = dbgByte'(randBits(6));
            end
            runReadMem(start, count, 0);
        end

        // Lengths over the payload limit
        runSetLed(dbgByte'(randBits(8)), 7);
        runReadMem(memAddr'(randBits(16)), dbgByte'(randBits(4)), 5);
        runSetLed(dbgByte'(randBits(8)), 1);

        repeat (3) runUnknownType();

        repeat (2) runDroppedMessage();

        $display("Sent %0d strobes in %0d cycles", strobeCount, cycleCount);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
